// File: src/dispatch_pkg.sv
// widths, stall bus bit positions, operation encodings and the decode-info word
package dispatch_pkg;

    localparam int XLEN            = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int COMMIT_ID_WIDTH = 2;
    localparam int STALL_WIDTH     = 2;

    // stall bus bit positions
    localparam int STALL_HOLD  = 0;
    localparam int STALL_FLUSH = 1;

    typedef enum logic [1:0] {
        GRP_NONE = 2'd0,
        GRP_ALU  = 2'd1,
        GRP_MEM  = 2'd2
    } unit_group_e;

    // opaque to dispatch, the ALU decodes it
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    typedef struct packed {
        alu_op_e op;
        logic    use_pc;
        logic    use_imm;
    } alu_view_t;

    typedef struct packed {
        logic      rsvd;
        logic      is_load;
        logic      is_store;
        mem_size_e size;
        logic      is_unsigned;
    } mem_view_t;

    // payload bits mean different things per unit group
    typedef union packed {
        alu_view_t alu;
        mem_view_t mem;
    } dec_payload_u;

    typedef struct packed {
        unit_group_e  grp;
        dec_payload_u payload;
    } dec_info_t;

endpackage

// File: src/dispatch_if.sv
// decoded ALU and memory requests between decoder and pipeline register
`timescale 1ns/1ns

interface dispatch_if;

    logic                          req_alu;
    logic [dispatch_pkg::XLEN-1:0] alu_op1;
    logic [dispatch_pkg::XLEN-1:0] alu_op2;
    dispatch_pkg::alu_op_e         alu_op;

    logic                          req_mem;
    logic                          mem_load;
    logic                          mem_store;
    logic                          mem_unsigned;
    dispatch_pkg::mem_size_e       mem_size;
    logic [dispatch_pkg::XLEN-1:0] mem_addr;
    logic [3:0]                    mem_wmask;
    logic [dispatch_pkg::XLEN-1:0] mem_wdata;
    logic                          misaligned_load;
    logic                          misaligned_store;

    modport producer (
        output req_alu, alu_op1, alu_op2, alu_op,
        output req_mem, mem_load, mem_store, mem_unsigned, mem_size,
        output mem_addr, mem_wmask, mem_wdata,
        output misaligned_load, misaligned_store
    );

    modport consumer (
        input req_alu, alu_op1, alu_op2, alu_op,
        input req_mem, mem_load, mem_store, mem_unsigned, mem_size,
        input mem_addr, mem_wmask, mem_wdata,
        input misaligned_load, misaligned_store
    );

endinterface

// File: src/hazard_unit.sv
// load scoreboard, commit ID allocation and register hazard stall
`timescale 1ns/1ns

module hazard_unit #(
    parameter int LONG_SLOTS = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     inst_valid_i,
    input  logic                                     is_load_i,
    input  logic                                     rd_we_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  rd_addr_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  rs1_addr_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  rs2_addr_i,
    input  logic                                     issue_i,
    input  logic                                     commit_valid_i,
    input  logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    output logic                                     hazard_stall_o,
    output logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] alloc_id_o
);

    logic [LONG_SLOTS-1:0]                   busy_q;
    logic [dispatch_pkg::REG_ADDR_WIDTH-1:0] rd_q [LONG_SLOTS];
    logic                                    free_any;
    logic                                    conflict;

    if (LONG_SLOTS > (1 << dispatch_pkg::COMMIT_ID_WIDTH)) begin : g_slot_check
        $error("commit ID too narrow for LONG_SLOTS");
    end

    // lowest free slot wins
    always_comb begin
        free_any   = 1'b0;
        alloc_id_o = '0;
        for (int i = LONG_SLOTS - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_any   = 1'b1;
                alloc_id_o = i[dispatch_pkg::COMMIT_ID_WIDTH-1:0];
            end
        end
    end

    // x0 never carries a dependency
    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < LONG_SLOTS; i++) begin
            if (busy_q[i]) begin
                if ((rs1_addr_i != '0 && rs1_addr_i == rd_q[i]) ||
                    (rs2_addr_i != '0 && rs2_addr_i == rd_q[i]) ||
                    (rd_we_i && rd_addr_i != '0 && rd_addr_i == rd_q[i])) begin
                    conflict = 1'b1;
                end
            end
        end
    end

    assign hazard_stall_o = inst_valid_i && (conflict || (is_load_i && !free_any));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (commit_valid_i) begin
                busy_q[commit_id_i] <= 1'b0;
            end
            if (issue_i && is_load_i) begin
                busy_q[alloc_id_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i && is_load_i) begin
            rd_q[alloc_id_o] <= rd_addr_i;
        end
    end

    // writeback may only retire tags that are outstanding
    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> busy_q[commit_id_i])
        else $error("commit of idle slot %0d", commit_id_i);

    // the pipe must honour the stall for a full scoreboard
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (issue_i && is_load_i) |-> free_any)
        else $error("load issued with no free slot");

endmodule

// File: src/dispatch_decode.sv
// operand selection and load/store address, byte mask and store data
`timescale 1ns/1ns

module dispatch_decode (
    input  dispatch_pkg::dec_info_t       dec_info_i,
    input  logic [dispatch_pkg::XLEN-1:0] dec_imm_i,
    input  logic [dispatch_pkg::XLEN-1:0] dec_pc_i,
    input  logic [dispatch_pkg::XLEN-1:0] rs1_rdata_i,
    input  logic [dispatch_pkg::XLEN-1:0] rs2_rdata_i,
    dispatch_if.producer                  req
);

    logic                          is_alu;
    logic                          is_mem;
    logic                          is_ld;
    logic                          is_st;
    logic                          misaligned;
    logic [dispatch_pkg::XLEN-1:0] addr;
    logic [3:0]                    lane_mask;
    logic [dispatch_pkg::XLEN-1:0] lane_data;

    assign is_alu = (dec_info_i.grp == dispatch_pkg::GRP_ALU);
    assign is_mem = (dec_info_i.grp == dispatch_pkg::GRP_MEM);
    assign is_ld  = is_mem && dec_info_i.payload.mem.is_load;
    assign is_st  = is_mem && dec_info_i.payload.mem.is_store;

    assign req.req_alu = is_alu;
    assign req.alu_op1 = dec_info_i.payload.alu.use_pc ? dec_pc_i : rs1_rdata_i;
    assign req.alu_op2 = dec_info_i.payload.alu.use_imm ? dec_imm_i : rs2_rdata_i;
    assign req.alu_op  = dec_info_i.payload.alu.op;

    // effective address
    assign addr = rs1_rdata_i + dec_imm_i;

    // byte lanes and alignment per access size
    always_comb begin
        case (dec_info_i.payload.mem.size)
            dispatch_pkg::SIZE_B: begin
                lane_mask  = 4'b0001 << addr[1:0];
                lane_data  = {4{rs2_rdata_i[7:0]}};
                misaligned = 1'b0;
            end
            dispatch_pkg::SIZE_H: begin
                lane_mask  = addr[1] ? 4'b1100 : 4'b0011;
                lane_data  = {2{rs2_rdata_i[15:0]}};
                misaligned = addr[0];
            end
            default: begin
                lane_mask  = 4'b1111;
                lane_data  = rs2_rdata_i;
                misaligned = (addr[1:0] != 2'b00);
            end
        endcase
    end

    assign req.req_mem          = is_mem;
    assign req.mem_load         = is_ld;
    assign req.mem_store        = is_st;
    assign req.mem_unsigned     = dec_info_i.payload.mem.is_unsigned;
    assign req.mem_size         = dec_info_i.payload.mem.size;
    assign req.mem_addr         = addr;
    // loads write nothing
    assign req.mem_wmask        = is_st ? lane_mask : 4'b0000;
    assign req.mem_wdata        = lane_data;
    assign req.misaligned_load  = is_ld && misaligned;
    assign req.misaligned_store = is_st && misaligned;

endmodule

// File: src/dispatch_pipe.sv
// dispatch pipeline register with hold, flush and bubble insertion
`timescale 1ns/1ns

module dispatch_pipe (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic [dispatch_pkg::STALL_WIDTH-1:0]     stall_flag_i,
    input  logic                                     inst_valid_i,
    input  logic                                     hazard_stall_i,
    input  logic [dispatch_pkg::XLEN-1:0]            inst_addr_i,
    input  logic                                     reg_we_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_i,
    input  logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    dispatch_if.consumer                             req,
    output logic                                     issue_o,

    output logic                                     inst_valid_o,
    output logic [dispatch_pkg::XLEN-1:0]            inst_addr_o,
    output logic                                     reg_we_o,
    output logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] commit_id_o,
    output logic                                     req_alu_o,
    output logic [dispatch_pkg::XLEN-1:0]            alu_op1_o,
    output logic [dispatch_pkg::XLEN-1:0]            alu_op2_o,
    output dispatch_pkg::alu_op_e                    alu_op_o,
    output logic                                     req_mem_o,
    output logic                                     mem_load_o,
    output logic                                     mem_store_o,
    output logic                                     mem_unsigned_o,
    output dispatch_pkg::mem_size_e                  mem_size_o,
    output logic [dispatch_pkg::XLEN-1:0]            mem_addr_o,
    output logic [3:0]                               mem_wmask_o,
    output logic [dispatch_pkg::XLEN-1:0]            mem_wdata_o,
    output logic                                     misaligned_load_o,
    output logic                                     misaligned_store_o
);

    logic hold;
    logic flush;

    assign hold    = stall_flag_i[dispatch_pkg::STALL_HOLD];
    assign flush   = stall_flag_i[dispatch_pkg::STALL_FLUSH];
    assign issue_o = inst_valid_i && !hazard_stall_i && !hold && !flush;

    // control bits, hold beats flush and bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
            req_alu_o    <= 1'b0;
            req_mem_o    <= 1'b0;
            reg_we_o     <= 1'b0;
        end else if (issue_o) begin
            inst_valid_o <= 1'b1;
            req_alu_o    <= req.req_alu;
            req_mem_o    <= req.req_mem;
            reg_we_o     <= reg_we_i;
        end else if (!hold) begin
            inst_valid_o <= 1'b0;
            req_alu_o    <= 1'b0;
            req_mem_o    <= 1'b0;
            reg_we_o     <= 1'b0;
        end
    end

    // payload only moves on issue
    always_ff @(posedge clk) begin
        if (issue_o) begin
            inst_addr_o        <= inst_addr_i;
            reg_waddr_o        <= reg_waddr_i;
            commit_id_o        <= commit_id_i;
            alu_op1_o          <= req.alu_op1;
            alu_op2_o          <= req.alu_op2;
            alu_op_o           <= req.alu_op;
            mem_load_o         <= req.mem_load;
            mem_store_o        <= req.mem_store;
            mem_unsigned_o     <= req.mem_unsigned;
            mem_size_o         <= req.mem_size;
            mem_addr_o         <= req.mem_addr;
            mem_wmask_o        <= req.mem_wmask;
            mem_wdata_o        <= req.mem_wdata;
            misaligned_load_o  <= req.misaligned_load;
            misaligned_store_o <= req.misaligned_store;
        end
    end

    // downstream sees a frozen instruction while held
    assert property (@(posedge clk) disable iff (!rst_n_i)
        hold |=> $stable({inst_valid_o, req_alu_o, req_mem_o, reg_we_o, inst_addr_o,
                          reg_waddr_o, commit_id_o, alu_op1_o, alu_op2_o, alu_op_o,
                          mem_load_o, mem_store_o, mem_unsigned_o, mem_size_o, mem_addr_o,
                          mem_wmask_o, mem_wdata_o, misaligned_load_o, misaligned_store_o}))
        else $error("pipe outputs changed under hold");

endmodule

// File: src/dispatch.sv
// dispatch stage top level joining decoder, hazard unit and pipeline register
`timescale 1ns/1ns

module dispatch #(
    parameter int LONG_SLOTS = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic [dispatch_pkg::STALL_WIDTH-1:0]     stall_flag_i,
    input  logic                                     inst_valid_i,
    input  dispatch_pkg::dec_info_t                  dec_info_i,
    input  logic [dispatch_pkg::XLEN-1:0]            dec_imm_i,
    input  logic [dispatch_pkg::XLEN-1:0]            dec_pc_i,
    input  logic [dispatch_pkg::XLEN-1:0]            rs1_rdata_i,
    input  logic [dispatch_pkg::XLEN-1:0]            rs2_rdata_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  reg1_raddr_i,
    input  logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  reg2_raddr_i,
    input  logic                                     reg_we_i,
    input  logic                                     commit_valid_i,
    input  logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    output logic                                     hazard_stall_o,

    output logic                                     pipe_inst_valid_o,
    output logic [dispatch_pkg::XLEN-1:0]            pipe_inst_addr_o,
    output logic                                     pipe_reg_we_o,
    output logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  pipe_reg_waddr_o,
    output logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] commit_id_o,
    output logic                                     req_alu_o,
    output logic [dispatch_pkg::XLEN-1:0]            alu_op1_o,
    output logic [dispatch_pkg::XLEN-1:0]            alu_op2_o,
    output dispatch_pkg::alu_op_e                    alu_op_o,
    output logic                                     req_mem_o,
    output logic                                     mem_load_o,
    output logic                                     mem_store_o,
    output logic                                     mem_unsigned_o,
    output dispatch_pkg::mem_size_e                  mem_size_o,
    output logic [dispatch_pkg::XLEN-1:0]            mem_addr_o,
    output logic [3:0]                               mem_wmask_o,
    output logic [dispatch_pkg::XLEN-1:0]            mem_wdata_o,
    output logic                                     misaligned_load_o,
    output logic                                     misaligned_store_o
);

    logic                                     issue;
    logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] alloc_id;

    dispatch_if req_bus ();

    dispatch_decode u_dispatch_decode (
        .dec_info_i  (dec_info_i),
        .dec_imm_i   (dec_imm_i),
        .dec_pc_i    (dec_pc_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .req         (req_bus.producer)
    );

    // loads are the only long instructions
    hazard_unit #(
        .LONG_SLOTS (LONG_SLOTS)
    ) u_hazard_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .is_load_i      (req_bus.mem_load),
        .rd_we_i        (reg_we_i),
        .rd_addr_i      (reg_waddr_i),
        .rs1_addr_i     (reg1_raddr_i),
        .rs2_addr_i     (reg2_raddr_i),
        .issue_i        (issue),
        .commit_valid_i (commit_valid_i),
        .commit_id_i    (commit_id_i),
        .hazard_stall_o (hazard_stall_o),
        .alloc_id_o     (alloc_id)
    );

    dispatch_pipe u_dispatch_pipe (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .stall_flag_i       (stall_flag_i),
        .inst_valid_i       (inst_valid_i),
        .hazard_stall_i     (hazard_stall_o),
        .inst_addr_i        (dec_pc_i),
        .reg_we_i           (reg_we_i),
        .reg_waddr_i        (reg_waddr_i),
        .commit_id_i        (alloc_id),
        .req                (req_bus.consumer),
        .issue_o            (issue),
        .inst_valid_o       (pipe_inst_valid_o),
        .inst_addr_o        (pipe_inst_addr_o),
        .reg_we_o           (pipe_reg_we_o),
        .reg_waddr_o        (pipe_reg_waddr_o),
        .commit_id_o        (commit_id_o),
        .req_alu_o          (req_alu_o),
        .alu_op1_o          (alu_op1_o),
        .alu_op2_o          (alu_op2_o),
        .alu_op_o           (alu_op_o),
        .req_mem_o          (req_mem_o),
        .mem_load_o         (mem_load_o),
        .mem_store_o        (mem_store_o),
        .mem_unsigned_o     (mem_unsigned_o),
        .mem_size_o         (mem_size_o),
        .mem_addr_o         (mem_addr_o),
        .mem_wmask_o        (mem_wmask_o),
        .mem_wdata_o        (mem_wdata_o),
        .misaligned_load_o  (misaligned_load_o),
        .misaligned_store_o (misaligned_store_o)
    );

endmodule

// File: dv/tb_dispatch.sv
// testbench for the dispatch stage with reference model, assertions and watchdog
`timescale 1ns/1ns

module tb_dispatch;

    localparam int LONG_SLOTS = 4;
    localparam int CLK_PERIOD = 8;
    localparam int N_RANDOM   = 60;
    localparam int N_DIRECTED = 10;

    logic                                     clk;
    logic                                     rst_n_i;
    logic [dispatch_pkg::STALL_WIDTH-1:0]     stall_flag_i;
    logic                                     inst_valid_i;
    dispatch_pkg::dec_info_t                  dec_info_i;
    logic [dispatch_pkg::XLEN-1:0]            dec_imm_i, dec_pc_i, rs1_rdata_i, rs2_rdata_i;
    logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_i, reg1_raddr_i, reg2_raddr_i;
    logic                                     reg_we_i, commit_valid_i;
    logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i, commit_id_o;
    logic                                     hazard_stall_o, pipe_inst_valid_o, pipe_reg_we_o;
    logic [dispatch_pkg::XLEN-1:0]            pipe_inst_addr_o;
    logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  pipe_reg_waddr_o;
    logic                                     req_alu_o, req_mem_o;
    logic [dispatch_pkg::XLEN-1:0]            alu_op1_o, alu_op2_o, mem_addr_o, mem_wdata_o;
    dispatch_pkg::alu_op_e                    alu_op_o;
    logic                                     mem_load_o, mem_store_o, mem_unsigned_o;
    dispatch_pkg::mem_size_e                  mem_size_o;
    logic [3:0]                               mem_wmask_o;
    logic                                     misaligned_load_o, misaligned_store_o;

    // reference scoreboard and expected pipe contents
    logic [LONG_SLOTS-1:0]                    busy_m;
    logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  rd_m [LONG_SLOTS];
    logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] free_slot, exp_cid;
    logic                                     free_any, conflict, exp_hazard, accept;
    logic                                     is_load, is_store, exp_is_load, exp_is_store;
    logic [dispatch_pkg::XLEN-1:0]            addr_now, exp_op1, exp_op2, exp_addr, exp_wdata;
    logic [dispatch_pkg::XLEN-1:0]            exp_pc;
    logic [dispatch_pkg::REG_ADDR_WIDTH-1:0]  exp_waddr;
    logic                                     exp_unsigned;
    logic [1:0]                               exp_size;
    logic [3:0]                               exp_ctrl;
    logic [3:0]                               exp_alu_op;
    logic [5:0]                               exp_mem_flags;
    logic [dispatch_pkg::COMMIT_ID_WIDTH-1:0] load_tags[$];
    string                                    test_name;

    dispatch #(.LONG_SLOTS(LONG_SLOTS)) DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [3:0] store_mask(logic [1:0] size, logic [1:0] a);
        case (size)
            dispatch_pkg::SIZE_B: return 4'b0001 << a;
            dispatch_pkg::SIZE_H: return a[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] store_data(logic [1:0] size, logic [31:0] d);
        case (size)
            dispatch_pkg::SIZE_B: return {4{d[7:0]}};
            dispatch_pkg::SIZE_H: return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic misaligned(logic [1:0] size, logic [1:0] a);
        case (size)
            dispatch_pkg::SIZE_B: return 1'b0;
            dispatch_pkg::SIZE_H: return a[0];
            default: return a != 2'b00;
        endcase
    endfunction

    function automatic dispatch_pkg::dec_info_t alu_info(logic [3:0] op, logic pc, logic imm);
        dispatch_pkg::dec_info_t info;
        info.grp                 = dispatch_pkg::GRP_ALU;
        info.payload.alu.op      = dispatch_pkg::alu_op_e'(op);
        info.payload.alu.use_pc  = pc;
        info.payload.alu.use_imm = imm;
        return info;
    endfunction

    function automatic dispatch_pkg::dec_info_t mem_info(logic ld, logic [1:0] size, logic uns);
        dispatch_pkg::dec_info_t info;
        info.grp                     = dispatch_pkg::GRP_MEM;
        info.payload.mem.rsvd        = 1'b0;
        info.payload.mem.is_load     = ld;
        info.payload.mem.is_store    = !ld;
        info.payload.mem.size        = dispatch_pkg::mem_size_e'(size);
        info.payload.mem.is_unsigned = uns;
        return info;
    endfunction

    assign is_load  = dec_info_i.grp == dispatch_pkg::GRP_MEM && dec_info_i.payload.mem.is_load;
    assign is_store = dec_info_i.grp == dispatch_pkg::GRP_MEM && dec_info_i.payload.mem.is_store;
    assign addr_now = rs1_rdata_i + dec_imm_i;
    assign accept   = inst_valid_i && !exp_hazard && stall_flag_i == '0;

    // stall on a busy destination or on a load with every tag taken
    always_comb begin
        free_any  = 1'b0;
        free_slot = '0;
        conflict  = 1'b0;
        for (int i = LONG_SLOTS - 1; i >= 0; i--) begin
            if (!busy_m[i]) begin
                free_any  = 1'b1;
                free_slot = i[dispatch_pkg::COMMIT_ID_WIDTH-1:0];
            end else if ((reg1_raddr_i != 0 && reg1_raddr_i == rd_m[i]) ||
                         (reg2_raddr_i != 0 && reg2_raddr_i == rd_m[i]) ||
                         (reg_we_i && reg_waddr_i != 0 && reg_waddr_i == rd_m[i])) begin
                conflict = 1'b1;
            end
        end
        exp_hazard = inst_valid_i && (conflict || (is_load && !free_any));
    end

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_m   <= '0;
            exp_ctrl <= '0;
        end else begin
            if (commit_valid_i) begin
                busy_m[commit_id_i] <= 1'b0;
            end
            if (accept) begin
                exp_ctrl <= {1'b1, dec_info_i.grp == dispatch_pkg::GRP_ALU,
                             dec_info_i.grp == dispatch_pkg::GRP_MEM, reg_we_i};
                exp_op1       <= dec_info_i.payload.alu.use_pc ? dec_pc_i : rs1_rdata_i;
                exp_op2       <= dec_info_i.payload.alu.use_imm ? dec_imm_i : rs2_rdata_i;
                exp_alu_op    <= dec_info_i.payload.alu.op;
                exp_addr      <= addr_now;
                exp_wdata     <= store_data(dec_info_i.payload.mem.size, rs2_rdata_i);
                exp_mem_flags <= {is_store ? store_mask(dec_info_i.payload.mem.size,
                                                        addr_now[1:0]) : 4'b0000,
                                  is_load && misaligned(dec_info_i.payload.mem.size, addr_now[1:0]),
                                  is_store && misaligned(dec_info_i.payload.mem.size, addr_now[1:0])};
                exp_is_load   <= is_load;
                exp_is_store  <= is_store;
                exp_unsigned  <= dec_info_i.payload.mem.is_unsigned;
                exp_size      <= dec_info_i.payload.mem.size;
                exp_pc        <= dec_pc_i;
                exp_waddr     <= reg_waddr_i;
                exp_cid       <= free_slot;
                if (is_load) begin
                    busy_m[free_slot] <= 1'b1;
                    rd_m[free_slot]   <= reg_waddr_i;
                    load_tags.push_back(free_slot);
                end
            end else if (!stall_flag_i[dispatch_pkg::STALL_HOLD]) begin
                exp_ctrl <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        {pipe_inst_valid_o, req_alu_o, req_mem_o, pipe_reg_we_o} == exp_ctrl)
        else report_mismatch("pipe control", $sampled(exp_ctrl),
                             $sampled({pipe_inst_valid_o, req_alu_o, req_mem_o, pipe_reg_we_o}));
    assert property (@(posedge clk) disable iff (!rst_n_i) hazard_stall_o == exp_hazard)
        else report_mismatch("hazard stall", $sampled(exp_hazard), $sampled(hazard_stall_o));
    assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_ctrl[3] |-> pipe_inst_addr_o == exp_pc)
        else report_mismatch("instruction address", $sampled(exp_pc),
                             $sampled(pipe_inst_addr_o));
    assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_ctrl[3] |-> pipe_reg_waddr_o == exp_waddr)
        else report_mismatch("destination register", $sampled(exp_waddr),
                             $sampled(pipe_reg_waddr_o));
    assert property (@(posedge clk) disable iff (!rst_n_i) exp_ctrl[2] |-> alu_op1_o == exp_op1)
        else report_mismatch("alu op1", $sampled(exp_op1), $sampled(alu_op1_o));
    assert property (@(posedge clk) disable iff (!rst_n_i) exp_ctrl[2] |-> alu_op2_o == exp_op2)
        else report_mismatch("alu op2", $sampled(exp_op2), $sampled(alu_op2_o));
    assert property (@(posedge clk) disable iff (!rst_n_i) exp_ctrl[2] |-> alu_op_o == exp_alu_op)
        else report_mismatch("alu opcode", $sampled(exp_alu_op), $sampled(alu_op_o));
    assert property (@(posedge clk) disable iff (!rst_n_i) exp_ctrl[1] |-> mem_addr_o == exp_addr)
        else report_mismatch("mem address", $sampled(exp_addr), $sampled(mem_addr_o));
    assert property (@(posedge clk) disable iff (!rst_n_i) exp_ctrl[1] |->
        {mem_load_o, mem_store_o, mem_unsigned_o, mem_size_o} ==
        {exp_is_load, exp_is_store, exp_unsigned, exp_size})
        else report_mismatch("mem kind", $sampled({exp_is_load, exp_is_store, exp_unsigned,
                                                   exp_size}),
                             $sampled({mem_load_o, mem_store_o, mem_unsigned_o, mem_size_o}));
    assert property (@(posedge clk) disable iff (!rst_n_i) exp_ctrl[1] |->
        {mem_wmask_o, misaligned_load_o, misaligned_store_o} == exp_mem_flags)
        else report_mismatch("mask and misaligned", $sampled(exp_mem_flags),
                             $sampled({mem_wmask_o, misaligned_load_o, misaligned_store_o}));
    assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_ctrl[1] && exp_is_store |-> mem_wdata_o == exp_wdata)
        else report_mismatch("store data", $sampled(exp_wdata), $sampled(mem_wdata_o));
    assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_ctrl[3] && exp_is_load |-> commit_id_o == exp_cid)
        else report_mismatch("commit id", $sampled(exp_cid), $sampled(commit_id_o));

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("[FAIL] %s, %s: expected %h, actual %h", test_name, name, expected, actual);
        stop_with_failure();
    endtask

    // operands are random, inputs stay put until the stage takes them
    task automatic send(dispatch_pkg::dec_info_t info, logic [4:0] rd, logic we,
                        logic [4:0] rs1, logic [4:0] rs2);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        dec_info_i   <= info;
        reg_waddr_i  <= rd;
        reg_we_i     <= we;
        reg1_raddr_i <= rs1;
        reg2_raddr_i <= rs2;
        dec_pc_i     <= $urandom & ~32'h3;
        dec_imm_i    <= $urandom_range(0, 4095);
        rs1_rdata_i  <= $urandom;
        rs2_rdata_i  <= $urandom;
        do begin
            @(posedge clk);
        end while (!accept);
        inst_valid_i <= 1'b0;
    endtask

    // writeback returns the oldest outstanding tag
    task automatic retire_load();
        @(posedge clk);
        commit_valid_i <= 1'b1;
        commit_id_i    <= load_tags.pop_front();
        @(posedge clk);
        commit_valid_i <= 1'b0;
    endtask

    initial begin
        #((N_DIRECTED + N_RANDOM) * 20 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles without finishing",
                 (N_DIRECTED + N_RANDOM) * 20);
        stop_with_failure();
    end

    initial begin
        void'($urandom(32'hf2a8));
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        stall_flag_i   = '0;
        inst_valid_i   = 1'b0;
        dec_info_i     = '0;
        dec_imm_i      = '0;
        dec_pc_i       = '0;
        rs1_rdata_i    = '0;
        rs2_rdata_i    = '0;
        reg_waddr_i    = '0;
        reg1_raddr_i   = '0;
        reg2_raddr_i   = '0;
        reg_we_i       = 1'b0;
        commit_valid_i = 1'b0;
        commit_id_i    = '0;
        test_name      = "reset";
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        test_name = "alu operands";
        repeat (N_RANDOM / 2) begin
            send(alu_info(4'($urandom_range(0, 10)), 1'($urandom), 1'($urandom)),
                 5'($urandom_range(1, 31)), 1'b1, 5'($urandom), 5'($urandom));
        end

        test_name = "loads and stores";
        repeat (N_RANDOM / 2) begin
            automatic logic ld = 1'($urandom);
            send(mem_info(ld, 2'($urandom_range(0, 2)), 1'($urandom)), ld ? 5'd12 : 5'd0, ld,
                 5'($urandom), 5'($urandom));
            if (ld) begin
                retire_load();
            end
        end

        test_name = "load use";
        send(mem_info(1'b1, dispatch_pkg::SIZE_W, 1'b0), 5'd7, 1'b1, 5'd1, 5'd2);
        fork
            send(alu_info(4'd0, 1'b0, 1'b0), 5'd8, 1'b1, 5'd7, 5'd3);
            begin
                repeat (4) @(posedge clk);
                retire_load();
            end
        join

        test_name = "full scoreboard";
        for (int r = 1; r <= LONG_SLOTS; r++) begin
            send(mem_info(1'b1, dispatch_pkg::SIZE_W, 1'b0), 5'(r), 1'b1, 5'd0, 5'd0);
        end
        fork
            send(mem_info(1'b1, dispatch_pkg::SIZE_H, 1'b1), 5'd9, 1'b1, 5'd0, 5'd0);
            begin
                repeat (4) @(posedge clk);
                retire_load();
            end
        join
        repeat (LONG_SLOTS) retire_load();

        // hold freezes the issued instruction while a store waits
        // flush then turns the waiting store into a bubble
        test_name = "hold and flush";
        send(alu_info(4'd5, 1'b0, 1'b1), 5'd3, 1'b1, 5'd1, 5'd2);
        inst_valid_i <= 1'b1;
        dec_info_i   <= mem_info(1'b0, dispatch_pkg::SIZE_W, 1'b0);
        reg_we_i     <= 1'b0;
        dec_pc_i     <= $urandom & ~32'h3;
        rs1_rdata_i  <= $urandom;
        rs2_rdata_i  <= $urandom;
        stall_flag_i[dispatch_pkg::STALL_HOLD] <= 1'b1;
        repeat (3) @(posedge clk);
        stall_flag_i <= '0;
        stall_flag_i[dispatch_pkg::STALL_FLUSH] <= 1'b1;
        @(posedge clk);
        stall_flag_i <= '0;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        repeat (3) @(posedge clk);

        $display("Test OK");
        $finish;
    end

endmodule

// File: tb.f
src/dispatch_pkg.sv
src/dispatch_if.sv
src/hazard_unit.sv
src/dispatch_decode.sv
src/dispatch_pipe.sv
src/dispatch.sv
dv/tb_dispatch.sv

// File: Bender.yml
package:
  name: dispatch

sources:
  - src/dispatch_pkg.sv
  - src/dispatch_if.sv
  - src/hazard_unit.sv
  - src/dispatch_decode.sv
  - src/dispatch_pipe.sv
  - src/dispatch.sv
  - target: test
    files:
      - dv/tb_dispatch.sv
